// File: hdl/dot_pkg.sv
package dot_pkg;

	localparam int DEPTH  = 8;
	localparam int IDX_W  = $clog2(DEPTH);
	localparam int OPND_W = 8;
	localparam int PROD_W = 2 * OPND_W;
	localparam int ACC_W  = 24;

	typedef logic [OPND_W-1:0] opnd_t;
	typedef logic [PROD_W-1:0] prod_t;
	typedef logic [ACC_W-1:0]  acc_t;
	typedef logic [IDX_W-1:0]  idx_t;

	// Operand b sits in the upper byte
	typedef struct packed {
		opnd_t b;
		opnd_t a;
	} pair_t;

	typedef enum logic [1:0] {
		OP_CLR     = 2'd0,
		OP_DOT     = 2'd1,
		OP_DOT_ACC = 2'd2
	} opcode_t;

	// Control word bits 4:3 opcode, bits 2:0 length minus one
	typedef struct packed {
		opcode_t opcode;
		idx_t    len_m1;
	} eng_ctrl_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_DRAIN,
		ST_DONE
	} dot_state_t;

endpackage

// File: hdl/axil_pkg.sv
package axil_pkg;

	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_t;

	typedef struct packed {
		logic              awvalid;
		logic [ADDR_W-1:0] awaddr;
		logic              wvalid;
		logic [DATA_W-1:0] wdata;
		logic              bready;
		logic              arvalid;
		logic [ADDR_W-1:0] araddr;
		logic              rready;
	} axil_req_t;

	typedef struct packed {
		logic              awready;
		logic              wready;
		logic              bvalid;
		resp_t             bresp;
		logic              arready;
		logic              rvalid;
		logic [DATA_W-1:0] rdata;
		resp_t             rresp;
	} axil_rsp_t;

	// Register map
	localparam logic [ADDR_W-1:0] REG_CTRL      = 8'h00;
	localparam logic [ADDR_W-1:0] REG_STATUS    = 8'h04;
	localparam logic [ADDR_W-1:0] REG_RESULT    = 8'h08;
	localparam logic [ADDR_W-1:0] REG_OPND_BASE = 8'h10;

endpackage

// File: hdl/dadda_mul8.sv
module dadda_mul8 (
	input  dot_pkg::opnd_t a,
	input  dot_pkg::opnd_t b,
	output dot_pkg::prod_t p
);
	import dot_pkg::*;

	// Compressor cells, result is {carry, sum}
	function automatic logic [1:0] ha(input logic x, input logic y);
		return {x & y, x ^ y};
	endfunction

	function automatic logic [1:0] fa(input logic x, input logic y, input logic z);
		return {(x & y) | (x & z) | (y & z), x ^ y ^ z};
	endfunction

	logic [OPND_W-1:0] pp [OPND_W];

	logic s1_1_1, c1_1_1, s1_2_1, c1_2_1, s1_3_1, c1_3_1, s1_4_1, c1_4_1;
	logic s1_4_2, c1_4_2, s1_5_1, c1_5_1, s1_5_2, c1_5_2, s1_6_1, c1_6_1;
	logic s1_6_2, c1_6_2, s1_7_1, c1_7_1, s1_7_2, c1_7_2, s1_7_3, c1_7_3;
	logic s1_8_1, c1_8_1, s1_8_2, c1_8_2, s1_9_1, c1_9_1, s1_9_2, c1_9_2;
	logic s1_10_1, c1_10_1, s1_10_2, c1_10_2, s1_11_1, c1_11_1;
	logic s1_12_1, c1_12_1, s1_13_1, c1_13_1;
	logic s2_2_1, c2_2_1, s2_3_1, c2_3_1, s2_4_1, c2_4_1, s2_5_1, c2_5_1;
	logic s2_6_1, c2_6_1, s2_6_2, c2_6_2, s2_7_1, c2_7_1, s2_7_2, c2_7_2;
	logic s2_8_1, c2_8_1, s2_8_2, c2_8_2, s2_9_1, c2_9_1, s2_10_1, c2_10_1;
	logic s2_11_1, c2_11_1, s2_12_1, c2_12_1, s2_13_1, c2_13_1, s2_14_1, c2_14_1;
	logic s3_3_1, c3_3_1, s3_4_1, c3_4_1, s3_5_1, c3_5_1, s3_6_1, c3_6_1;
	logic s3_7_1, c3_7_1, s3_8_1, c3_8_1, s3_9_1, c3_9_1, s3_10_1, c3_10_1;
	logic s3_11_1, c3_11_1, s3_12_1, c3_12_1, s3_13_1, c3_13_1, s3_14_1, c3_14_1;
	logic s4_4_1, c4_4_1, s4_5_1, c4_5_1, s4_6_1, c4_6_1, s4_7_1, c4_7_1;
	logic s4_8_1, c4_8_1, s4_9_1, c4_9_1, s4_10_1, c4_10_1, s4_11_1, c4_11_1;
	logic s4_12_1, c4_12_1, s4_13_1, c4_13_1, s4_14_1, c4_14_1, s4_15_1;
	prod_t row_a, row_b;

	// pp[i][j] is a[i] & b[j]
	always_comb begin
		for (int i = 0; i < OPND_W; i++) begin
			pp[i] = b & {OPND_W{a[i]}};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stage 1, columns down to height 6
	assign {c1_1_1, s1_1_1}   = ha(pp[0][1], pp[1][0]);
	assign {c1_2_1, s1_2_1}   = fa(pp[0][2], pp[1][1], pp[2][0]);
	assign {c1_3_1, s1_3_1}   = fa(pp[0][3], pp[1][2], pp[2][1]);
	assign {c1_4_1, s1_4_1}   = fa(pp[0][4], pp[1][3], pp[2][2]);
	assign {c1_4_2, s1_4_2}   = ha(pp[3][1], pp[4][0]);
	assign {c1_5_1, s1_5_1}   = fa(pp[0][5], pp[1][4], pp[2][3]);
	assign {c1_5_2, s1_5_2}   = fa(pp[3][2], pp[4][1], pp[5][0]);
	assign {c1_6_1, s1_6_1}   = fa(pp[0][6], pp[1][5], pp[2][4]);
	assign {c1_6_2, s1_6_2}   = fa(pp[3][3], pp[4][2], pp[5][1]);
	assign {c1_7_1, s1_7_1}   = fa(pp[0][7], pp[1][6], pp[2][5]);
	assign {c1_7_2, s1_7_2}   = fa(pp[3][4], pp[4][3], pp[5][2]);
	assign {c1_7_3, s1_7_3}   = ha(pp[6][1], pp[7][0]);
	assign {c1_8_1, s1_8_1}   = fa(pp[1][7], pp[2][6], pp[3][5]);
	assign {c1_8_2, s1_8_2}   = fa(pp[4][4], pp[5][3], pp[6][2]);
	assign {c1_9_1, s1_9_1}   = fa(pp[2][7], pp[3][6], pp[4][5]);
	assign {c1_9_2, s1_9_2}   = fa(pp[5][4], pp[6][3], pp[7][2]);
	assign {c1_10_1, s1_10_1} = fa(pp[3][7], pp[4][6], pp[5][5]);
	assign {c1_10_2, s1_10_2} = ha(pp[6][4], pp[7][3]);
	assign {c1_11_1, s1_11_1} = fa(pp[4][7], pp[5][6], pp[6][5]);
	assign {c1_12_1, s1_12_1} = fa(pp[5][7], pp[6][6], pp[7][5]);
	assign {c1_13_1, s1_13_1} = ha(pp[6][7], pp[7][6]);

	// Stage 2
	assign {c2_2_1, s2_2_1}   = ha(s1_2_1, c1_1_1);
	assign {c2_3_1, s2_3_1}   = fa(pp[3][0], s1_3_1, c1_2_1);
	assign {c2_4_1, s2_4_1}   = fa(s1_4_2, s1_4_1, c1_3_1);
	assign {c2_5_1, s2_5_1}   = fa(s1_5_2, s1_5_1, c1_4_2);
	assign {c2_6_1, s2_6_1}   = fa(pp[6][0], s1_6_2, s1_6_1);
	assign {c2_6_2, s2_6_2}   = ha(c1_5_2, c1_5_1);
	assign {c2_7_1, s2_7_1}   = fa(s1_7_3, s1_7_2, s1_7_1);
	assign {c2_7_2, s2_7_2}   = ha(c1_6_2, c1_6_1);
	assign {c2_8_1, s2_8_1}   = fa(pp[7][1], s1_8_2, s1_8_1);
	assign {c2_8_2, s2_8_2}   = fa(c1_7_3, c1_7_2, c1_7_1);
	assign {c2_9_1, s2_9_1}   = fa(s1_9_2, s1_9_1, c1_8_2);
	assign {c2_10_1, s2_10_1} = fa(s1_10_2, s1_10_1, c1_9_2);
	assign {c2_11_1, s2_11_1} = fa(pp[7][4], s1_11_1, c1_10_2);
	assign {c2_12_1, s2_12_1} = ha(s1_12_1, c1_11_1);
	assign {c2_13_1, s2_13_1} = ha(s1_13_1, c1_12_1);
	assign {c2_14_1, s2_14_1} = ha(pp[7][7], c1_13_1);

	// Stage 3
	assign {c3_3_1, s3_3_1}   = ha(s2_3_1, c2_2_1);
	assign {c3_4_1, s3_4_1}   = ha(s2_4_1, c2_3_1);
	assign {c3_5_1, s3_5_1}   = fa(c1_4_1, s2_5_1, c2_4_1);
	assign {c3_6_1, s3_6_1}   = fa(s2_6_2, s2_6_1, c2_5_1);
	assign {c3_7_1, s3_7_1}   = fa(s2_7_2, s2_7_1, c2_6_2);
	assign {c3_8_1, s3_8_1}   = fa(s2_8_2, s2_8_1, c2_7_2);
	assign {c3_9_1, s3_9_1}   = fa(c1_8_1, s2_9_1, c2_8_2);
	assign {c3_10_1, s3_10_1} = fa(c1_9_1, s2_10_1, c2_9_1);
	assign {c3_11_1, s3_11_1} = fa(c1_10_1, s2_11_1, c2_10_1);
	assign {c3_12_1, s3_12_1} = ha(s2_12_1, c2_11_1);
	assign {c3_13_1, s3_13_1} = ha(s2_13_1, c2_12_1);
	assign {c3_14_1, s3_14_1} = ha(s2_14_1, c2_13_1);

	// Stage 4, two rows left
	assign {c4_4_1, s4_4_1}   = ha(s3_4_1, c3_3_1);
	assign {c4_5_1, s4_5_1}   = ha(s3_5_1, c3_4_1);
	assign {c4_6_1, s4_6_1}   = ha(s3_6_1, c3_5_1);
	assign {c4_7_1, s4_7_1}   = fa(c2_6_1, s3_7_1, c3_6_1);
	assign {c4_8_1, s4_8_1}   = fa(c2_7_1, s3_8_1, c3_7_1);
	assign {c4_9_1, s4_9_1}   = fa(c2_8_1, s3_9_1, c3_8_1);
	assign {c4_10_1, s4_10_1} = ha(s3_10_1, c3_9_1);
	assign {c4_11_1, s4_11_1} = ha(s3_11_1, c3_10_1);
	assign {c4_12_1, s4_12_1} = ha(s3_12_1, c3_11_1);
	assign {c4_13_1, s4_13_1} = ha(s3_13_1, c3_12_1);
	assign {c4_14_1, s4_14_1} = ha(s3_14_1, c3_13_1);
	// Carry out of bit 15 is always zero for an 8x8 product
	assign s4_15_1 = c2_14_1 ^ c3_14_1;

	//////////////////////////////////////////////////////////////////////
	// Final carry-propagate sum
	assign row_a = {s4_15_1, s4_14_1, s4_13_1, s4_12_1, s4_11_1, s4_10_1,
		s4_9_1, s4_8_1, s4_7_1, s4_6_1, s4_5_1, 5'b00000};
	assign row_b = {c4_14_1, c4_13_1, c4_12_1, c4_11_1, c4_10_1, c4_9_1,
		c4_8_1, c4_7_1, c4_6_1, c4_5_1, c4_4_1,
		s4_4_1, s3_3_1, s2_2_1, s1_1_1, pp[0][0]};
	assign p = row_a + row_b;

endmodule

// File: hdl/operand_buffer.sv
module operand_buffer (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            we,
	input  dot_pkg::idx_t   widx,
	input  dot_pkg::pair_t  wdata,
	input  dot_pkg::idx_t   ridx,
	output dot_pkg::pair_t  rdata,
	output dot_pkg::pair_t  bus_rdata
);
	import dot_pkg::*;

	pair_t mem [DEPTH];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[widx] <= wdata;
		end
	end

	// Engine read port
	assign rdata = mem[ridx];

	// Bus readback shares the write index
	assign bus_rdata = mem[widx];

endmodule

// File: hdl/elem_counter.sv
module elem_counter (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           load,
	input  logic           step,
	input  dot_pkg::idx_t  last_idx,
	output dot_pkg::idx_t  idx,
	output logic           last
);
	import dot_pkg::*;

	idx_t cnt_q;
	idx_t end_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q <= '0;
			end_q <= '0;
		end else if (load) begin
			cnt_q <= '0;
			end_q <= last_idx;
		end else if (step) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	assign idx  = cnt_q;
	assign last = (cnt_q == end_q);

endmodule

// File: hdl/dot_fsm.sv
module dot_fsm (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  dot_pkg::eng_ctrl_t ctrl,
	input  logic               last,
	output logic               cnt_load,
	output logic               cnt_step,
	output logic               acc_clr,
	output logic               prod_en,
	output logic               hold_prev,
	output logic               busy,
	output logic               done_pulse,
	output dot_pkg::idx_t      len_m1
);
	import dot_pkg::*;

	dot_state_t state_q, state_d;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d    = state_q;
		cnt_load   = 1'b0;
		cnt_step   = 1'b0;
		acc_clr    = 1'b0;
		prod_en    = 1'b0;
		hold_prev  = 1'b0;
		done_pulse = 1'b0;
		case (state_q)
			ST_IDLE: begin
				if (start) begin
					case (ctrl.opcode)
						OP_DOT: begin
							acc_clr  = 1'b1;
							cnt_load = 1'b1;
							state_d  = ST_RUN;
						end
						OP_DOT_ACC: begin
							acc_clr   = 1'b1;
							hold_prev = 1'b1;
							cnt_load  = 1'b1;
							state_d   = ST_RUN;
						end
						OP_CLR: begin
							acc_clr = 1'b1;
							state_d = ST_DONE;
						end
						// Reserved opcode only reports done
						default: state_d = ST_DONE;
					endcase
				end
			end
			// One pair per cycle into the multiplier stage
			ST_RUN: begin
				prod_en = 1'b1;
				if (last) begin
					state_d = ST_DRAIN;
				end else begin
					cnt_step = 1'b1;
				end
			end
			ST_DRAIN: state_d = ST_DONE;
			ST_DONE: begin
				done_pulse = 1'b1;
				state_d    = ST_IDLE;
			end
			default: state_d = ST_IDLE;
		endcase
	end

	assign busy   = (state_q != ST_IDLE);
	assign len_m1 = ctrl.len_m1;

endmodule

// File: hdl/dot_accum.sv
module dot_accum (
	input  logic           clk,
	input  logic           rst_n,
	input  dot_pkg::prod_t prod,
	input  logic           prod_en,
	input  logic           acc_clr,
	input  logic           hold_prev,
	output dot_pkg::acc_t  result
);
	import dot_pkg::*;

	prod_t stage_q;
	logic  stage_vld;
	acc_t  acc_q;

	always_ff @(posedge clk) begin
		if (prod_en) begin
			stage_q <= prod;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage_vld <= 1'b0;
			acc_q     <= '0;
		end else if (acc_clr) begin
			stage_vld <= 1'b0;
			// Keep the old sum for an accumulating run
			if (!hold_prev) begin
				acc_q <= '0;
			end
		end else begin
			stage_vld <= prod_en;
			if (stage_vld) begin
				acc_q <= acc_q + acc_t'(stage_q);
			end
		end
	end

	assign result = acc_q;

endmodule

// File: hdl/axil_regs.sv
module axil_regs (
	input  logic                 clk,
	input  logic                 rst_n,
	input  axil_pkg::axil_req_t  req,
	output axil_pkg::axil_rsp_t  rsp,
	input  logic                 busy,
	input  logic                 done_pulse,
	input  dot_pkg::acc_t        result,
	input  dot_pkg::pair_t       opnd_rdata,
	output logic                 opnd_we,
	output dot_pkg::idx_t        opnd_idx,
	output dot_pkg::pair_t       opnd_wdata,
	output logic                 start,
	output dot_pkg::eng_ctrl_t   ctrl
);
	import dot_pkg::*;
	import axil_pkg::*;

	function automatic logic opnd_hit(input logic [ADDR_W-1:0] addr);
		logic [ADDR_W-1:0] off;
		off = addr - REG_OPND_BASE;
		return (off < ADDR_W'(DEPTH * 4)) && (off[1:0] == 2'b00);
	endfunction

	function automatic idx_t opnd_sel(input logic [ADDR_W-1:0] addr);
		logic [ADDR_W-1:0] off;
		off = addr - REG_OPND_BASE;
		return off[IDX_W+1:2];
	endfunction

	logic              wr_acc, rd_acc, busy_any, ctrl_we;
	logic              bvalid_q, rvalid_q, start_q, done_q;
	resp_t             bresp_q, rresp_q;
	logic [DATA_W-1:0] rdata_q, rd_data;
	logic              rd_err;
	eng_ctrl_t         ctrl_q;

	// Reads yield to a write in the same cycle, the operand index is shared
	assign wr_acc   = req.awvalid & req.wvalid & ~bvalid_q;
	assign rd_acc   = req.arvalid & ~rvalid_q & ~wr_acc;
	assign busy_any = busy | start_q;

	assign ctrl_we    = wr_acc & (req.awaddr == REG_CTRL) & ~busy_any;
	assign opnd_we    = wr_acc & opnd_hit(req.awaddr) & ~busy_any;
	assign opnd_idx   = wr_acc ? opnd_sel(req.awaddr) : opnd_sel(req.araddr);
	assign opnd_wdata = pair_t'(req.wdata[$bits(pair_t)-1:0]);

	always_comb begin
		rd_err  = 1'b0;
		rd_data = '0;
		if (req.araddr == REG_CTRL) begin
			rd_data = DATA_W'(ctrl_q);
		end else if (req.araddr == REG_STATUS) begin
			rd_data = DATA_W'({done_q, busy_any});
		end else if (req.araddr == REG_RESULT) begin
			rd_data = DATA_W'(result);
		end else if (opnd_hit(req.araddr)) begin
			rd_data = DATA_W'(opnd_rdata);
		end else begin
			rd_err = 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Control, sticky done and response channels
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
			start_q  <= 1'b0;
			done_q   <= 1'b0;
			ctrl_q   <= '0;
		end else begin
			start_q <= ctrl_we;
			if (ctrl_we) begin
				ctrl_q <= eng_ctrl_t'(req.wdata[$bits(eng_ctrl_t)-1:0]);
				done_q <= 1'b0;
			end else if (done_pulse) begin
				done_q <= 1'b1;
			end
			if (wr_acc) begin
				bvalid_q <= 1'b1;
			end else if (req.bready) begin
				bvalid_q <= 1'b0;
			end
			if (rd_acc) begin
				rvalid_q <= 1'b1;
			end else if (req.rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_acc) begin
			bresp_q <= (ctrl_we | opnd_we) ? RESP_OKAY : RESP_SLVERR;
		end
		if (rd_acc) begin
			rdata_q <= rd_data;
			rresp_q <= rd_err ? RESP_SLVERR : RESP_OKAY;
		end
	end

	always_comb begin
		rsp         = '0;
		rsp.awready = wr_acc;
		rsp.wready  = wr_acc;
		rsp.bvalid  = bvalid_q;
		rsp.bresp   = bresp_q;
		rsp.arready = rd_acc;
		rsp.rvalid  = rvalid_q;
		rsp.rdata   = rdata_q;
		rsp.rresp   = rresp_q;
	end

	assign start = start_q;
	assign ctrl  = ctrl_q;

endmodule

// File: hdl/dot_engine_top.sv
module dot_engine_top (
	input  logic                clk,
	input  logic                rst_n,
	input  axil_pkg::axil_req_t bus_req,
	output axil_pkg::axil_rsp_t bus_rsp
);
	import dot_pkg::*;

	logic      opnd_we, start, busy, done_pulse, last;
	logic      cnt_load, cnt_step, acc_clr, prod_en, hold_prev;
	idx_t      opnd_idx, idx, len_m1;
	pair_t     opnd_wdata, opnd_rdata, pair;
	eng_ctrl_t ctrl;
	prod_t     prod;
	acc_t      result;

	axil_regs u_axil_regs (
		.clk, .rst_n,
		.req        (bus_req),
		.rsp        (bus_rsp),
		.busy, .done_pulse, .result, .opnd_rdata,
		.opnd_we, .opnd_idx, .opnd_wdata,
		.start, .ctrl
	);

	operand_buffer u_operand_buffer (
		.clk, .rst_n,
		.we         (opnd_we),
		.widx       (opnd_idx),
		.wdata      (opnd_wdata),
		.ridx       (idx),
		.rdata      (pair),
		.bus_rdata  (opnd_rdata)
	);

	dot_fsm u_dot_fsm (
		.clk, .rst_n,
		.start, .ctrl, .last,
		.cnt_load, .cnt_step, .acc_clr, .prod_en, .hold_prev,
		.busy, .done_pulse, .len_m1
	);

	elem_counter u_elem_counter (
		.clk, .rst_n,
		.load       (cnt_load),
		.step       (cnt_step),
		.last_idx   (len_m1),
		.idx, .last
	);

	dadda_mul8 u_dadda_mul8 (
		.a          (pair.a),
		.b          (pair.b),
		.p          (prod)
	);

	dot_accum u_dot_accum (
		.clk, .rst_n,
		.prod, .prod_en, .acc_clr, .hold_prev,
		.result
	);

endmodule

// File: verif/tb_dot_engine.sv
module tb_dot_engine;
	import dot_pkg::*;
	import axil_pkg::*;

	localparam int N_PAT     = 13;
	localparam int PAT_W     = 11;
	localparam int N_RAND    = 6;
	localparam int N_WRAP    = 33;
	localparam int N_MISC    = 3;
	localparam int CYC_LIMIT = (N_PAT + N_RAND + N_WRAP + N_MISC) * 60;

	logic        clk = 1'b0;
	logic        rst_n;
	axil_req_t   bus_req;
	axil_rsp_t   bus_rsp;
	logic [23:0] pat_mem [N_PAT * PAT_W];
	pair_t       cur_pairs [DEPTH];
	logic [31:0] rng_state;
	int          stall_mod;
	int          cycles = 0;

	dot_engine_top u_dot_engine_top (
		.clk,
		.rst_n,
		.bus_req,
		.bus_rsp
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYC_LIMIT) begin
			$display("Timeout after %0d cycles, the bus or the engine stopped answering", cycles);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Random numbers and the reference sum
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic int pick_stall();
		return int'(next_rand() % 32'(stall_mod));
	endfunction

	// Sum of a*b over the first n pairs modulo 2^24
	function automatic acc_t model_dot(input acc_t start, input int n);
		acc_t s;
		s = start;
		for (int i = 0; i < n; i++) begin
			s = s + acc_t'(cur_pairs[i].a) * acc_t'(cur_pairs[i].b);
		end
		return s;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_result(input string name, input acc_t exp, input acc_t act);
		if (act !== exp) begin
			abort_run($sformatf("Fail %s: expected %06h, actual %06h", name, exp, act));
		end
	endtask

	task automatic check_resp(input string name, input resp_t exp, input resp_t act);
		if (act !== exp) begin
			abort_run($sformatf("Fail %s: expected resp %02b, actual resp %02b", name, exp, act));
		end
	endtask

	task automatic check_pair(input string name, input pair_t exp, input pair_t act);
		if (act !== exp) begin
			abort_run($sformatf("Fail %s: expected pair %04h, actual pair %04h", name, exp, act));
		end
	endtask

	// Status bit 1 done, bit 0 busy
	task automatic check_status(input string name, input logic [1:0] exp,
		input logic [1:0] act);
		if (act !== exp) begin
			abort_run($sformatf("Fail %s: expected status %02b, actual status %02b",
				name, exp, act));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// AXI4-Lite master
	task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		output resp_t resp);
		int stall;
		stall = pick_stall();
		@(posedge clk);
		bus_req.awvalid <= 1'b1;
		bus_req.awaddr  <= addr;
		bus_req.wvalid  <= 1'b1;
		bus_req.wdata   <= data;
		@(negedge clk);
		while (!bus_rsp.awready) @(negedge clk);
		if (!bus_rsp.wready) begin
			abort_run("Write data was not accepted together with the write address");
		end
		@(posedge clk);
		bus_req.awvalid <= 1'b0;
		bus_req.wvalid  <= 1'b0;
		repeat (stall) @(posedge clk);
		bus_req.bready <= 1'b1;
		@(negedge clk);
		while (!bus_rsp.bvalid) @(negedge clk);
		resp = bus_rsp.bresp;
		@(posedge clk);
		bus_req.bready <= 1'b0;
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
		output resp_t resp);
		int stall;
		stall = pick_stall();
		@(posedge clk);
		bus_req.arvalid <= 1'b1;
		bus_req.araddr  <= addr;
		@(negedge clk);
		while (!bus_rsp.arready) @(negedge clk);
		@(posedge clk);
		bus_req.arvalid <= 1'b0;
		@(negedge clk);
		while (!bus_rsp.rvalid) @(negedge clk);
		data = bus_rsp.rdata;
		resp = bus_rsp.rresp;
		// Response must stay put while rready is low
		repeat (stall + 1) @(posedge clk);
		bus_req.rready <= 1'b1;
		@(negedge clk);
		if (bus_rsp.rvalid !== 1'b1 || bus_rsp.rdata !== data) begin
			abort_run("Read response changed while the master held rready low");
		end
		@(posedge clk);
		bus_req.rready <= 1'b0;
	endtask

	task automatic write_pair(input string name, input int idx, input pair_t p);
		resp_t resp;
		bus_write(REG_OPND_BASE + ADDR_W'(4 * idx), DATA_W'(p), resp);
		check_resp(name, RESP_OKAY, resp);
		cur_pairs[idx] = p;
	endtask

	task automatic start_op(input string name, input opcode_t op, input idx_t len_m1);
		eng_ctrl_t ctrl;
		resp_t     resp;
		ctrl.opcode = op;
		ctrl.len_m1 = len_m1;
		bus_write(REG_CTRL, DATA_W'(ctrl), resp);
		check_resp(name, RESP_OKAY, resp);
	endtask

	// Poll until the sticky done bit
	task automatic wait_done(input string name);
		logic [DATA_W-1:0] status;
		resp_t             resp;
		status = '0;
		while (status[1] !== 1'b1) begin
			bus_read(REG_STATUS, status, resp);
			check_resp(name, RESP_OKAY, resp);
		end
	endtask

	task automatic expect_result(input string name, input acc_t exp);
		logic [DATA_W-1:0] data;
		resp_t             resp;
		bus_read(REG_RESULT, data, resp);
		check_resp(name, RESP_OKAY, resp);
		check_result(name, exp, acc_t'(data[ACC_W-1:0]));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	initial begin
		logic [DATA_W-1:0] data;
		resp_t             resp;
		acc_t              exp_sum;
		pair_t             keep;
		string             name;
		int                base;
		int                len;

		bus_req   = '0;
		rst_n     = 1'b0;
		rng_state = 32'd49;
		stall_mod = 3;
		$readmemh("verif/dot_patterns.txt", pat_mem);
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		bus_read(REG_STATUS, data, resp);
		check_resp("reset status", RESP_OKAY, resp);
		check_status("reset status", 2'b00, data[1:0]);
		expect_result("reset result", '0);
		bus_read(REG_OPND_BASE, data, resp);
		check_resp("reset pair", RESP_OKAY, resp);
		check_pair("reset pair", '0, pair_t'(data[15:0]));

		// Operand readback
		for (int i = 0; i < DEPTH; i++) begin
			write_pair($sformatf("write pair %0d", i), i, pair_t'(16'(next_rand())));
		end
		for (int i = 0; i < DEPTH; i++) begin
			name = $sformatf("read pair %0d", i);
			bus_read(REG_OPND_BASE + ADDR_W'(4 * i), data, resp);
			check_resp(name, RESP_OKAY, resp);
			check_pair(name, cur_pairs[i], pair_t'(data[15:0]));
		end

		// Directed patterns
		for (int t = 0; t < N_PAT; t++) begin
			base = t * PAT_W;
			name = $sformatf("pattern %0d", t + 1);
			for (int i = 0; i < DEPTH; i++) begin
				write_pair(name, i, pair_t'(pat_mem[base + 2 + i][15:0]));
			end
			start_op(name, opcode_t'(pat_mem[base][1:0]), idx_t'(pat_mem[base + 1][2:0]));
			wait_done(name);
			expect_result(name, acc_t'(pat_mem[base + 10]));
		end

		// Accumulate past 2^24
		for (int i = 0; i < DEPTH; i++) begin
			write_pair("wrap setup", i, pair_t'(16'hffff));
		end
		start_op("wrap clear", OP_CLR, '0);
		wait_done("wrap clear");
		expect_result("wrap clear", '0);
		exp_sum = '0;
		for (int r = 0; r < N_WRAP; r++) begin
			name    = $sformatf("wrap run %0d", r + 1);
			exp_sum = model_dot(exp_sum, DEPTH);
			start_op(name, OP_DOT_ACC, idx_t'(DEPTH - 1));
			wait_done(name);
			expect_result(name, exp_sum);
		end

		for (int r = 0; r < N_RAND; r++) begin
			name = $sformatf("random %0d", r + 1);
			len  = 1 + int'(next_rand() % 32'(DEPTH));
			for (int i = 0; i < DEPTH; i++) begin
				write_pair(name, i, pair_t'(16'(next_rand())));
			end
			start_op(name, OP_DOT, idx_t'(len - 1));
			wait_done(name);
			expect_result(name, model_dot('0, len));
		end

		//////////////////////////////////////////////////////////////////////
		// Error responses
		bus_write(8'h40, 32'h0000_1234, resp);
		check_resp("unmapped write", RESP_SLVERR, resp);
		bus_read(8'h0c, data, resp);
		check_resp("unmapped read", RESP_SLVERR, resp);
		bus_write(REG_RESULT, 32'h0000_0001, resp);
		check_resp("result write", RESP_SLVERR, resp);

		// No stalls so the write lands inside the run
		stall_mod = 1;
		keep      = pair_t'(16'h1234);
		write_pair("busy setup", 0, keep);
		start_op("busy run", OP_DOT, idx_t'(DEPTH - 1));
		bus_read(REG_STATUS, data, resp);
		check_resp("busy status", RESP_OKAY, resp);
		check_status("busy status", 2'b01, data[1:0]);
		bus_write(REG_OPND_BASE, 32'h0000_abcd, resp);
		check_resp("write while busy", RESP_SLVERR, resp);
		stall_mod = 3;
		wait_done("busy run");
		bus_read(REG_OPND_BASE, data, resp);
		check_resp("pair after busy write", RESP_OKAY, resp);
		check_pair("pair after busy write", keep, pair_t'(data[15:0]));
		expect_result("busy run", model_dot('0, DEPTH));

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: verif/dot_patterns.txt
// opcode len_m1 pair0 pair1 pair2 pair3 pair4 pair5 pair6 pair7 expected
// pair is {b, a} in hex, opcode 0 clear, 1 dot, 2 dot onto previous result
// Dot products, lengths 1 to 8
1 0 0503 1111 2222 3333 4444 5555 6666 7777 00000f
1 1 0203 0405 ffff ffff ffff ffff ffff ffff 00001a
1 2 0a0a 0b0b 0c0c 0101 0101 0101 0101 0101 00016d
1 3 0101 0202 0303 0404 ffff ffff ffff ffff 00001e
1 4 1010 2020 3030 4040 5050 0000 0000 0000 003700
1 5 00ff ff00 0180 8001 ff01 01ff 7f7f 7f7f 0002fe
1 6 0102 0304 0506 0708 090a 0b0c 0d0e ffff 0001f8
1 7 ffff ffff ffff ffff ffff ffff ffff ffff 07f008
// Accumulate onto the previous result
2 7 ffff ffff ffff ffff ffff ffff ffff ffff 0fe010
2 0 0302 0000 0000 0000 0000 0000 0000 0000 0fe016
// Clear, then accumulate from zero
0 0 0000 0000 0000 0000 0000 0000 0000 0000 000000
2 1 0404 0505 0000 0000 0000 0000 0000 0000 000029
1 7 8080 8080 8080 8080 8080 8080 8080 8080 020000

// File: all.f
hdl/dot_pkg.sv
hdl/axil_pkg.sv
hdl/dadda_mul8.sv
hdl/operand_buffer.sv
hdl/elem_counter.sv
hdl/dot_fsm.sv
hdl/dot_accum.sv
hdl/axil_regs.sv
hdl/dot_engine_top.sv
verif/tb_dot_engine.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_dot_engine
FILELIST   ?= all.f
OBJDIR     ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
